// ==== rtl/coreParamsPkg.sv ====
package coreParamsPkg;

    // Buffer holds 2**ROB_ID_LEN entries
    localparam int ROB_ID_LEN = 5;

    // Rename lanes feeding the buffer per cycle
    localparam int DEC_WIDTH = 4;

    // Ops that may retire in one cycle
    localparam int COMMIT_WIDTH = 4;

    // Execution write-back ports
    localparam int WB_WIDTH = 2;

    // Physical register tag
    localparam int TAG_LEN = 7;

    // Architectural register name
    localparam int NAME_LEN = 5;

endpackage

// ==== rtl/uopPkg.sv ====
package uopPkg;

    // One extra msb tells apart two passes over the buffer
    typedef logic [coreParamsPkg::ROB_ID_LEN:0] SqN;

    typedef logic [coreParamsPkg::TAG_LEN-1:0] Tag;

    typedef logic [coreParamsPkg::NAME_LEN-1:0] RegName;

    typedef logic [3:0] FetchId;

    // FP codes map onto the fflags vector as code - FP_NX
    typedef enum logic [3:0] {
        NONE       = 4'd0,
        BRANCH     = 4'd1,
        FP_NX      = 4'd2,
        FP_UF      = 4'd3,
        FP_OF      = 4'd4,
        FP_DZ      = 4'd5,
        FP_NV      = 4'd6,
        PRED_TAKEN = 4'd7,
        ILLEGAL    = 4'd8,
        TRAP       = 4'd9,
        NX         = 4'd15
    } Flags;

    typedef struct packed {
        SqN     sqN;
        Tag     tagDst;
        RegName nmDst;
        logic   isFp;
        logic   isTrap;
        FetchId fetchId;
    } RenameUop;

    typedef struct packed {
        logic valid;
        SqN   sqN;
        Tag   tagDst;
        Flags flags;
    } WbUop;

    // Low sqN bits are implied by the entry index
    typedef struct packed {
        logic   valid;
        logic   sqNMsb;
        Flags   flags;
        Tag     tag;
        RegName name;
        logic   isFp;
        FetchId fetchId;
    } RobEntry;

    typedef struct packed {
        logic   valid;
        SqN     sqN;
        RegName nmDst;
        Tag     tagDst;
        logic   isBranch;
    } CommitUop;

    typedef struct packed {
        logic   valid;
        SqN     sqN;
        Flags   flags;
        RegName name;
        Tag     tag;
        FetchId fetchId;
        logic   allowInterrupt;
    } TrapUop;

endpackage

// ==== rtl/robWindowIf.sv ====
interface robWindowIf #(
    parameter int WIDTH = coreParamsPkg::COMMIT_WIDTH
);

    // Oldest entries, lane i holds base + i
    uopPkg::RobEntry entries [WIDTH-1:0];
    uopPkg::SqN baseIndex;

    // Rollback walk in progress, commit must idle
    logic replay;

    // Number of lanes retired this cycle
    logic [$clog2(WIDTH+1)-1:0] retireCount;

    // Commit paused for the cycle after a trap
    logic stop;

    modport storage (
        output entries,
        output baseIndex,
        output replay,
        input  retireCount,
        input  stop
    );

    modport commit (
        input  entries,
        input  baseIndex,
        input  replay,
        output retireCount,
        output stop
    );

endinterface

// ==== rtl/renameSlotSort.sv ====
module renameSlotSort (
    input  uopPkg::RenameUop inUop [coreParamsPkg::DEC_WIDTH-1:0],
    input  logic inValid [coreParamsPkg::DEC_WIDTH-1:0],
    output uopPkg::RenameUop sortedUop [coreParamsPkg::DEC_WIDTH-1:0],
    output logic sortedValid [coreParamsPkg::DEC_WIDTH-1:0]
);

    localparam int WIDTH = coreParamsPkg::DEC_WIDTH;
    localparam int SLOT_BITS = $clog2(WIDTH);

    // Rename hands out consecutive sqNs in a group, so at most one lane
    // matches each slot
    always_comb begin
        for (int slot = 0; slot < WIDTH; slot++) begin
            sortedValid[slot] = 1'b0;
            sortedUop[slot] = '0;
            for (int lane = 0; lane < WIDTH; lane++) begin
                if (inValid[lane] &&
                    inUop[lane].sqN[SLOT_BITS-1:0] == SLOT_BITS'(slot)) begin
                    sortedValid[slot] = 1'b1;
                    sortedUop[slot] = inUop[lane];
                end
            end
        end
    end

endmodule

// ==== rtl/reorderBuffer.sv ====
module reorderBuffer #(
    parameter int ID_LEN = coreParamsPkg::ROB_ID_LEN,
    parameter int WB_WIDTH = coreParamsPkg::WB_WIDTH
) (
    input  logic clk,
    input  logic rst,
    input  uopPkg::RenameUop sortedUop [coreParamsPkg::DEC_WIDTH-1:0],
    input  logic sortedValid [coreParamsPkg::DEC_WIDTH-1:0],
    input  uopPkg::WbUop wbUop [WB_WIDTH-1:0],
    input  logic branchTaken,
    input  uopPkg::SqN branchSqN,
    input  uopPkg::FetchId branchFetchId,
    robWindowIf.storage window,
    output uopPkg::SqN curSqN,
    output uopPkg::SqN maxSqN,
    output uopPkg::CommitUop replayUop [coreParamsPkg::COMMIT_WIDTH-1:0],
    output logic mispredFlush,
    output uopPkg::FetchId curFetchIdFlush
);

    localparam int LENGTH = 1 << ID_LEN;
    localparam int COM_WIDTH = coreParamsPkg::COMMIT_WIDTH;
    localparam int DEC_WIDTH = coreParamsPkg::DEC_WIDTH;
    localparam int SLOT_BITS = $clog2(DEC_WIDTH);
    // Top tag bit on a rollback op says the result was already produced
    localparam uopPkg::Tag DONE_MARK = uopPkg::Tag'(1) << (coreParamsPkg::TAG_LEN - 1);

    uopPkg::RobEntry entries [LENGTH-1:0];
    uopPkg::RobEntry winEntries [COM_WIDTH-1:0];
    uopPkg::SqN baseIndex;
    uopPkg::SqN nextBase;
    logic [$clog2(COM_WIDTH+1)-1:0] retireNow;
    logic [ID_LEN-1:0] readPtr;

    logic replay;
    logic replayEnd;
    uopPkg::SqN replayIter;
    uopPkg::SqN replayEndSqN;

    assign curSqN = baseIndex;
    assign maxSqN = baseIndex + uopPkg::SqN'(LENGTH - 1);

    // No retirement while rolling back or paused after a trap
    assign retireNow = (!replay && !window.stop) ? window.retireCount : '0;
    assign nextBase = baseIndex + uopPkg::SqN'(retireNow);

    // Window follows the replay iterator during rollback
    assign readPtr = replay ? replayIter[ID_LEN-1:0] : baseIndex[ID_LEN-1:0];

    always_comb begin
        for (int i = 0; i < COM_WIDTH; i++) begin
            winEntries[i] = entries[readPtr + ID_LEN'(i)];
        end
    end

    assign window.entries = winEntries;
    assign window.baseIndex = baseIndex;
    assign window.replay = replay;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LENGTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < COM_WIDTH; i++) begin
                if (i < retireNow) begin
                    entries[baseIndex[ID_LEN-1:0] + ID_LEN'(i)].valid <= 1'b0;
                end
            end

            if (branchTaken) begin
                // Drop everything younger than the branch
                for (int i = 0; i < LENGTH; i++) begin
                    if ($signed({entries[i].sqNMsb, ID_LEN'(i)} - branchSqN) > 0) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end else begin
                // Sorted slots write a fixed bank each
                for (int i = 0; i < DEC_WIDTH; i++) begin
                    if (sortedValid[i]) begin
                        entries[{sortedUop[i].sqN[ID_LEN-1:SLOT_BITS], SLOT_BITS'(i)}] <= '{
                            valid: 1'b1,
                            sqNMsb: sortedUop[i].sqN[ID_LEN],
                            flags: sortedUop[i].isTrap ? uopPkg::TRAP : uopPkg::NX,
                            tag: sortedUop[i].tagDst,
                            name: sortedUop[i].nmDst,
                            isFp: sortedUop[i].isFp,
                            fetchId: sortedUop[i].fetchId
                        };
                    end
                end
            end

            // Ops up to and including the branch still complete
            for (int i = 0; i < WB_WIDTH; i++) begin
                if (wbUop[i].valid &&
                    (!branchTaken || $signed(wbUop[i].sqN - branchSqN) <= 0)) begin
                    entries[wbUop[i].sqN[ID_LEN-1:0]].flags <= wbUop[i].flags;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            baseIndex <= '0;
            replay <= 1'b0;
            replayEnd <= 1'b0;
            replayIter <= '0;
            replayEndSqN <= '0;
            mispredFlush <= 1'b0;
            curFetchIdFlush <= '1;
            for (int i = 0; i < COM_WIDTH; i++) begin
                replayUop[i] <= '0;
            end
        end else begin
            for (int i = 0; i < COM_WIDTH; i++) begin
                replayUop[i] <= '0;
            end
            baseIndex <= nextBase;

            if (branchTaken) begin
                replay <= 1'b1;
                replayEnd <= 1'b0;
                replayIter <= nextBase;
                replayEndSqN <= branchSqN;
                mispredFlush <= 1'b0;
                curFetchIdFlush <= branchFetchId;
            end else if (replay) begin
                if (replayEnd) begin
                    replay <= 1'b0;
                    mispredFlush <= 1'b0;
                end else begin
                    // Hand rename everything from the oldest op up to the branch
                    mispredFlush <= 1'b1;
                    for (int i = 0; i < COM_WIDTH; i++) begin
                        if ($signed(replayIter + uopPkg::SqN'(i) - replayEndSqN) <= 0) begin
                            replayUop[i].valid <= 1'b1;
                            replayUop[i].sqN <= '0;
                            replayUop[i].nmDst <= (winEntries[i].flags == uopPkg::TRAP) ?
                                '0 : winEntries[i].name;
                            replayUop[i].tagDst <= (winEntries[i].flags == uopPkg::NX) ?
                                winEntries[i].tag : (winEntries[i].tag | DONE_MARK);
                            replayUop[i].isBranch <= 1'b0;
                        end else begin
                            replayEnd <= 1'b1;
                        end
                    end
                    replayIter <= replayIter + uopPkg::SqN'(COM_WIDTH);
                end
            end
        end
    end

endmodule

// ==== rtl/commitSelect.sv ====
module commitSelect (
    input  logic clk,
    input  logic rst,
    input  logic interruptPending,
    robWindowIf.commit window,
    output uopPkg::CommitUop comUop [coreParamsPkg::COMMIT_WIDTH-1:0],
    output uopPkg::TrapUop trapUop,
    output logic [4:0] fpFlags,
    output logic [coreParamsPkg::COMMIT_WIDTH-1:0] retireMask,
    output logic [coreParamsPkg::COMMIT_WIDTH-1:0] branchMask,
    output uopPkg::FetchId curFetchId
);

    localparam int WIDTH = coreParamsPkg::COMMIT_WIDTH;
    localparam int ID_LEN = coreParamsPkg::ROB_ID_LEN;

    uopPkg::CommitUop comNext [WIDTH-1:0];
    uopPkg::TrapUop trapNext;
    logic [4:0] fpNext;
    logic [WIDTH-1:0] retireNext;
    logic [WIDTH-1:0] branchNext;
    uopPkg::FetchId fetchIdNext;
    logic [$clog2(WIDTH+1)-1:0] count;
    logic stopNext;
    logic stopReg;

    always_comb begin
        logic groupEnd;
        logic predSeen;
        uopPkg::RobEntry e;
        logic [ID_LEN-1:0] idx;

        predSeen = 1'b0;
        count = '0;
        stopNext = 1'b0;
        fpNext = '0;
        retireNext = '0;
        branchNext = '0;
        trapNext = '0;
        fetchIdNext = curFetchId;
        for (int i = 0; i < WIDTH; i++) begin
            comNext[i] = '0;
        end

        // Idle during rollback and in the cycle after a trap
        groupEnd = window.replay || stopReg;

        for (int i = 0; i < WIDTH; i++) begin
            e = window.entries[i];
            idx = window.baseIndex[ID_LEN-1:0] + ID_LEN'(i);
            if (!groupEnd && e.valid && e.flags != uopPkg::NX &&
                (!predSeen || e.flags == uopPkg::NONE)) begin
                comNext[i].valid = 1'b1;
                comNext[i].sqN = {e.sqNMsb, idx};
                comNext[i].nmDst = e.name;
                comNext[i].tagDst = e.tag;
                comNext[i].isBranch = e.flags == uopPkg::BRANCH || e.flags == uopPkg::PRED_TAKEN;
                count = count + 1'b1;
                fetchIdNext = e.fetchId;
                retireNext[i] = e.flags != uopPkg::ILLEGAL && e.flags != uopPkg::TRAP;
                branchNext[i] = comNext[i].isBranch;

                if (e.flags == uopPkg::PRED_TAKEN) begin
                    predSeen = 1'b1;
                end

                if (e.flags == uopPkg::ILLEGAL || e.flags == uopPkg::TRAP || interruptPending) begin
                    trapNext.valid = 1'b1;
                    trapNext.sqN = {e.sqNMsb, idx};
                    trapNext.flags = e.flags;
                    trapNext.name = e.name;
                    trapNext.tag = e.tag;
                    trapNext.fetchId = e.fetchId;
                    trapNext.allowInterrupt = interruptPending;
                    // Faulting op must not update architectural state
                    if (e.flags == uopPkg::ILLEGAL) begin
                        comNext[i].nmDst = '0;
                    end
                    stopNext = 1'b1;
                    groupEnd = 1'b1;
                end else if (e.isFp && e.flags >= uopPkg::FP_NX && e.flags <= uopPkg::FP_NV) begin
                    fpNext[3'(e.flags - uopPkg::FP_NX)] = 1'b1;
                    // Underflow and overflow also raise inexact (bit 0)
                    if (e.flags == uopPkg::FP_UF || e.flags == uopPkg::FP_OF) begin
                        fpNext[0] = 1'b1;
                    end
                end
            end else begin
                groupEnd = 1'b1;
            end
        end
    end

    assign window.retireCount = count;
    assign window.stop = stopReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WIDTH; i++) begin
                comUop[i] <= '0;
            end
            trapUop <= '0;
            fpFlags <= '0;
            retireMask <= '0;
            branchMask <= '0;
            curFetchId <= '1;
            stopReg <= 1'b0;
        end else begin
            for (int i = 0; i < WIDTH; i++) begin
                comUop[i] <= comNext[i];
            end
            trapUop <= trapNext;
            fpFlags <= fpNext;
            retireMask <= retireNext;
            branchMask <= branchNext;
            curFetchId <= fetchIdNext;
            stopReg <= stopNext;
        end
    end

endmodule

// ==== rtl/robTop.sv ====
module robTop #(
    parameter int ID_LEN = coreParamsPkg::ROB_ID_LEN,
    parameter int WB_WIDTH = coreParamsPkg::WB_WIDTH
) (
    input  logic clk,
    input  logic rst,
    input  uopPkg::RenameUop inUop [coreParamsPkg::DEC_WIDTH-1:0],
    input  logic inValid [coreParamsPkg::DEC_WIDTH-1:0],
    input  uopPkg::WbUop wbUop [WB_WIDTH-1:0],
    input  logic branchTaken,
    input  uopPkg::SqN branchSqN,
    input  uopPkg::FetchId branchFetchId,
    input  logic interruptPending,
    output uopPkg::SqN curSqN,
    output uopPkg::SqN maxSqN,
    output uopPkg::CommitUop comUop [coreParamsPkg::COMMIT_WIDTH-1:0],
    output uopPkg::TrapUop trapUop,
    output logic [4:0] fpFlags,
    output logic [coreParamsPkg::COMMIT_WIDTH-1:0] retireMask,
    output logic [coreParamsPkg::COMMIT_WIDTH-1:0] branchMask,
    output uopPkg::FetchId curFetchId,
    output logic mispredFlush,
    output uopPkg::FetchId curFetchIdFlush
);

    localparam int COM_WIDTH = coreParamsPkg::COMMIT_WIDTH;

    uopPkg::RenameUop sortedUop [coreParamsPkg::DEC_WIDTH-1:0];
    logic sortedValid [coreParamsPkg::DEC_WIDTH-1:0];
    uopPkg::CommitUop replayUop [COM_WIDTH-1:0];
    uopPkg::CommitUop retireUop [COM_WIDTH-1:0];

    robWindowIf #(.WIDTH(COM_WIDTH)) window ();

    renameSlotSort sorter (
        .inUop(inUop),
        .inValid(inValid),
        .sortedUop(sortedUop),
        .sortedValid(sortedValid)
    );

    reorderBuffer #(
        .ID_LEN(ID_LEN),
        .WB_WIDTH(WB_WIDTH)
    ) storage (
        .clk(clk),
        .rst(rst),
        .sortedUop(sortedUop),
        .sortedValid(sortedValid),
        .wbUop(wbUop),
        .branchTaken(branchTaken),
        .branchSqN(branchSqN),
        .branchFetchId(branchFetchId),
        .window(window.storage),
        .curSqN(curSqN),
        .maxSqN(maxSqN),
        .replayUop(replayUop),
        .mispredFlush(mispredFlush),
        .curFetchIdFlush(curFetchIdFlush)
    );

    commitSelect commitStage (
        .clk(clk),
        .rst(rst),
        .interruptPending(interruptPending),
        .window(window.commit),
        .comUop(retireUop),
        .trapUop(trapUop),
        .fpFlags(fpFlags),
        .retireMask(retireMask),
        .branchMask(branchMask),
        .curFetchId(curFetchId)
    );

    // Commit idles during rollback, so the two sources never overlap
    always_comb begin
        for (int i = 0; i < COM_WIDTH; i++) begin
            comUop[i] = replayUop[i].valid ? replayUop[i] : retireUop[i];
        end
    end

endmodule

// ==== dv/robTop_assertions.sv ====
module robTop_assertions (
    input logic clk,
    input logic rst,
    input logic [3:0] comValid,
    input logic trapValid,
    input logic mispredFlush
);

    // Number of assertion failures so far
    int failCount = 0;

    // Commit pauses for one cycle after a trap record
    assert property (@(posedge clk) disable iff (rst)
        trapValid |=> (comValid == 4'b0) || mispredFlush)
        else begin
            $error("commit seen in the cycle after a trap");
            failCount++;
        end

    assert property (@(posedge clk) $past(rst) && !rst |-> !mispredFlush)
        else begin
            $error("mispredFlush high right after reset");
            failCount++;
        end

endmodule

bind robTop robTop_assertions robTopChecks (
    .clk(clk),
    .rst(rst),
    .comValid({comUop[3].valid, comUop[2].valid, comUop[1].valid, comUop[0].valid}),
    .trapValid(trapUop.valid),
    .mispredFlush(mispredFlush)
);

// ==== dv/robTb.sv ====
module robTb;

    localparam int DEC = coreParamsPkg::DEC_WIDTH;
    localparam int COM = coreParamsPkg::COMMIT_WIDTH;
    localparam int WBW = coreParamsPkg::WB_WIDTH;
    localparam int MAX_WAIT = 200;

    logic clk;
    logic rst;
    uopPkg::RenameUop inUop [DEC-1:0];
    logic inValid [DEC-1:0];
    uopPkg::WbUop wbUop [WBW-1:0];
    logic branchTaken;
    uopPkg::SqN branchSqN;
    uopPkg::FetchId branchFetchId;
    logic interruptPending;
    uopPkg::SqN curSqN;
    uopPkg::SqN maxSqN;
    uopPkg::CommitUop comUop [COM-1:0];
    uopPkg::TrapUop trapUop;
    logic [4:0] fpFlags;
    logic [COM-1:0] retireMask;
    logic [COM-1:0] branchMask;
    uopPkg::FetchId curFetchId;
    logic mispredFlush;
    uopPkg::FetchId curFetchIdFlush;

    logic [31:0] lfsrState = 32'hc0b9dc55;
    int errors = 0;
    int nextSqN = 0;
    int expSqN = 0;
    int commitCount = 0;
    int replayCount = 0;
    int retireBits = 0;
    int branchBits = 0;
    int trapCount = 0;
    logic [4:0] fpAcc = '0;
    logic stopPending = 1'b0;
    uopPkg::TrapUop lastTrap;
    uopPkg::Tag comTag [64];
    int wbSq [$];
    uopPkg::Flags wbFl [$];

    robTop robTop_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic int lfsrBits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
        end
        return r;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Errors: %0d (timeout)", errors + 1);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    // Observe outputs at the falling edge, where they are stable
    always @(negedge clk) begin
        if (!rst) begin
            if (stopPending) begin
                for (int i = 0; i < COM; i++) begin
                    if (comUop[i].valid && !mispredFlush) begin
                        $display("A commit was seen in the cycle after a trap");
                        errors++;
                    end
                end
            end
            stopPending = trapUop.valid;
            if (trapUop.valid) begin
                lastTrap = trapUop;
                trapCount++;
            end
            if (mispredFlush) begin
                checkVal("retireMask", retireMask, 0);
            end
            fpAcc |= fpFlags;
            for (int i = 0; i < COM; i++) begin
                if (comUop[i].valid && mispredFlush) begin
                    replayCount++;
                end else if (comUop[i].valid) begin
                    checkVal("comUop.sqN", comUop[i].sqN, expSqN[5:0]);
                    comTag[comUop[i].sqN] = comUop[i].tagDst;
                    expSqN++;
                    commitCount++;
                    if (retireMask[i]) retireBits++;
                    if (branchMask[i]) branchBits++;
                end
            end
        end
    end

    // Groups of up to four, placed in reversed lanes for the sorter
    task automatic enqueueOps(input int n, input int tagBase, input logic fp, input logic trap);
        int done;
        int k;
        done = 0;
        while (done < n) begin
            k = (n - done > DEC) ? DEC : n - done;
            for (int j = 0; j < k; j++) begin
                inUop[DEC-1-j] = '{sqN: uopPkg::SqN'(nextSqN + j),
                    tagDst: uopPkg::Tag'(tagBase + done + j),
                    nmDst: uopPkg::RegName'(done + j + 1), isFp: fp, isTrap: trap,
                    fetchId: uopPkg::FetchId'(done + j)};
                inValid[DEC-1-j] = 1'b1;
            end
            tick();
            for (int j = 0; j < DEC; j++) begin
                inValid[j] = 1'b0;
            end
            nextSqN += k;
            done += k;
        end
    endtask

    // Drains wbSq/wbFl in shuffled order, two per cycle
    task automatic writeBackShuffled();
        int j;
        int s;
        uopPkg::Flags f;
        for (int i = wbSq.size() - 1; i > 0; i--) begin
            j = lfsrBits(5) % (i + 1);
            s = wbSq[i];
            wbSq[i] = wbSq[j];
            wbSq[j] = s;
            f = wbFl[i];
            wbFl[i] = wbFl[j];
            wbFl[j] = f;
        end
        while (wbSq.size() > 0) begin
            for (int p = 0; p < WBW; p++) begin
                wbUop[p] = '0;
                if (wbSq.size() > 0) begin
                    wbUop[p].valid = 1'b1;
                    wbUop[p].sqN = uopPkg::SqN'(wbSq.pop_front());
                    wbUop[p].flags = wbFl.pop_front();
                end
            end
            tick();
        end
        wbUop[0] = '0;
        wbUop[1] = '0;
    endtask

    task automatic waitCommits(input int target);
        int c;
        c = 0;
        while (commitCount < target) begin
            if (c >= MAX_WAIT) timeoutFail("commits");
            c++;
            tick();
        end
    endtask

    task automatic waitTrap(input int target);
        int c;
        c = 0;
        while (trapCount < target) begin
            if (c >= MAX_WAIT) timeoutFail("a trap record");
            c++;
            tick();
        end
    endtask

    task automatic testReset();
        checkVal("curSqN", curSqN, 0);
        checkVal("maxSqN", maxSqN, 31);
        checkVal("trapUop.valid", trapUop.valid, 0);
        checkVal("fpFlags", fpFlags, 0);
        checkVal("retireMask", retireMask, 0);
        checkVal("mispredFlush", mispredFlush, 0);
        checkVal("curFetchId", curFetchId, 4'hf);
        for (int i = 0; i < COM; i++) begin
            checkVal("comUop.valid", comUop[i].valid, 0);
        end
    endtask

    task automatic testInOrder();
        int start;
        start = nextSqN;
        enqueueOps(8, 0, 1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            wbSq.push_back(start + i);
            wbFl.push_back(uopPkg::NONE);
        end
        writeBackShuffled();
        waitCommits(start + 8);
        checkVal("curSqN", curSqN, 8);
    endtask

    task automatic testFpFlags();
        int start;
        start = nextSqN;
        fpAcc = '0;
        retireBits = 0;
        enqueueOps(3, 8, 1'b1, 1'b0);
        wbSq = '{start, start + 1, start + 2};
        wbFl = '{uopPkg::FP_UF, uopPkg::FP_DZ, uopPkg::FP_NV};
        writeBackShuffled();
        waitCommits(start + 3);
        tick();
        checkVal("fpFlags", fpAcc, 5'h1b);
        checkVal("retireMask bits", retireBits, 3);
    endtask

    task automatic testTrap();
        int s;
        s = nextSqN;
        // Two trap ops back to back, the second is ready during the pause
        enqueueOps(2, 12, 1'b0, 1'b1);
        waitTrap(1);
        checkVal("trapUop.sqN", lastTrap.sqN, s);
        checkVal("trapUop.flags", lastTrap.flags, uopPkg::TRAP);
        checkVal("trapUop.allowInterrupt", lastTrap.allowInterrupt, 0);
        waitTrap(2);
        checkVal("trapUop.sqN", lastTrap.sqN, s + 1);
        tick();
        tick();
        s = nextSqN;
        enqueueOps(1, 14, 1'b0, 1'b0);
        interruptPending = 1'b1;
        wbSq = '{s};
        wbFl = '{uopPkg::NONE};
        writeBackShuffled();
        waitTrap(3);
        tick();
        interruptPending = 1'b0;
        checkVal("trapUop.sqN", lastTrap.sqN, s);
        checkVal("trapUop.allowInterrupt", lastTrap.allowInterrupt, 1);
        waitCommits(s + 1);
    endtask

    task automatic testMispredict();
        int b;
        int c;
        b = nextSqN;
        replayCount = 0;
        enqueueOps(10, 16, 1'b0, 1'b0);
        // The two oldest ops complete on the branch edge itself
        branchTaken = 1'b1;
        branchSqN = uopPkg::SqN'(b + 4);
        branchFetchId = 4'h5;
        for (int p = 0; p < WBW; p++) begin
            wbUop[p] = '0;
            wbUop[p].valid = 1'b1;
            wbUop[p].sqN = uopPkg::SqN'(b + p);
            wbUop[p].flags = uopPkg::NONE;
        end
        tick();
        branchTaken = 1'b0;
        for (int p = 0; p < WBW; p++) begin
            wbUop[p] = '0;
        end
        c = 0;
        while (!mispredFlush) begin
            if (c >= MAX_WAIT) timeoutFail("mispredFlush to rise");
            c++;
            tick();
        end
        c = 0;
        while (mispredFlush) begin
            if (c >= MAX_WAIT) timeoutFail("mispredFlush to fall");
            c++;
            tick();
        end
        checkVal("replayed ops", replayCount, 5);
        checkVal("curSqN", curSqN, b);
        checkVal("curFetchIdFlush", curFetchIdFlush, 4'h5);
        // Completing the squashed ops must not let them retire
        for (int i = 2; i < 10; i++) begin
            wbSq.push_back(b + i);
            wbFl.push_back(uopPkg::NONE);
        end
        writeBackShuffled();
        waitCommits(b + 5);
        repeat (4) tick();
        checkVal("commitCount", commitCount, b + 5);
        nextSqN = b + 5;
        enqueueOps(5, 48, 1'b0, 1'b0);
        for (int i = 5; i < 10; i++) begin
            wbSq.push_back(b + i);
            wbFl.push_back(uopPkg::NONE);
        end
        writeBackShuffled();
        waitCommits(b + 10);
        for (int i = 5; i < 10; i++) begin
            checkVal("comUop.tagDst", comTag[b + i], 48 + i - 5);
        end
    endtask

    task automatic testBranchStats();
        int start;
        start = nextSqN;
        branchBits = 0;
        enqueueOps(3, 60, 1'b0, 1'b0);
        wbSq = '{start, start + 1, start + 2};
        wbFl = '{uopPkg::BRANCH, uopPkg::PRED_TAKEN, uopPkg::NONE};
        writeBackShuffled();
        waitCommits(start + 3);
        checkVal("branchMask bits", branchBits, 2);
    endtask

    initial begin
        rst = 1'b1;
        branchTaken = 1'b0;
        branchSqN = '0;
        branchFetchId = '0;
        interruptPending = 1'b0;
        for (int i = 0; i < DEC; i++) begin
            inUop[i] = '0;
            inValid[i] = 1'b0;
        end
        for (int i = 0; i < WBW; i++) begin
            wbUop[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        testReset();
        testInOrder();
        testFpFlags();
        testTrap();
        testMispredict();
        testBranchStats();
        repeat (4) tick();
        $display("Errors: %0d, assertion failures: %0d, commits seen: %0d",
            errors, robTop_inst.robTopChecks.failCount, commitCount);
        if (errors == 0 && robTop_inst.robTopChecks.failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/coreParamsPkg.sv
rtl/uopPkg.sv
rtl/robWindowIf.sv
rtl/renameSlotSort.sv
rtl/reorderBuffer.sv
rtl/commitSelect.sv
rtl/robTop.sv
dv/robTop_assertions.sv
dv/robTb.sv
